/* compile.f */
design/big_mul_pkg.sv
design/mac_ctrl_if.sv
design/block_ram.sv
design/operand_loader.sv
design/mul_sequencer.sv
design/block_multiplier.sv
design/carry_accumulator.sv
design/big_mul_top.sv
tb/clk_gen.sv
tb/big_mul_tb.sv

/* design/big_mul_pkg.sv */
package big_mul_pkg;

    // word and block geometry
    localparam int word_w = 32;
    localparam int block_w = 2 * word_w;
    localparam int operand_bits = 256;
    localparam int operand_blocks = operand_bits / block_w;
    localparam int load_words = operand_bits / word_w;
    localparam int acc_blocks = 2 * operand_blocks;
    localparam int result_words = 2 * load_words;
    localparam int addr_w = $clog2(acc_blocks);

    // counter widths and pipeline depth
    localparam int load_cnt_w = $clog2(load_words);
    localparam int out_cnt_w = $clog2(result_words) + 1;
    localparam int drain_cycles = 3;

    typedef logic [word_w-1:0] word_t;
    typedef logic [block_w-1:0] block_t;
    typedef logic [addr_w-1:0] addr_t;

    typedef enum logic [1:0] {
        st_idle,
        st_loading,
        st_computing,
        st_outputting
    } seq_state_t;

endpackage

/* design/big_mul_top.sv */
module big_mul_top import big_mul_pkg::*; (
    input  logic  clk_in,
    input  logic  rst,
    input  word_t operand_n,
    input  word_t operand_m,
    input  logic  load_valid,
    output logic  ready,
    output word_t result_word,
    output logic  result_valid,
    output logic  result_last
);

    // operand memory write side
    logic n_wr_en;
    logic m_wr_en;
    addr_t op_wr_addr;
    block_t n_wr_data;
    block_t m_wr_data;
    logic load_done;

    // read side
    addr_t n_rd_addr;
    addr_t m_rd_addr;
    addr_t acc_rd_addr;
    block_t n_rd_data;
    block_t m_rd_data;
    block_t acc_rd_data;

    block_t product_lo;
    block_t product_hi;

    logic acc_wr_en;
    addr_t acc_wr_addr;
    block_t acc_wr_data;

    mac_ctrl_if issue_ctrl ();
    mac_ctrl_if mac_ctrl ();

    operand_loader u_loader (
        .clk_in    (clk_in),
        .rst       (rst),
        .operand_n (operand_n),
        .operand_m (operand_m),
        .load_valid(load_valid),
        .accept    (ready),
        .n_wr_en   (n_wr_en),
        .m_wr_en   (m_wr_en),
        .wr_addr   (op_wr_addr),
        .n_wr_data (n_wr_data),
        .m_wr_data (m_wr_data),
        .load_done (load_done)
    );

    block_ram u_n_mem (
        .clk_in (clk_in),
        .wr_en  (n_wr_en),
        .wr_addr(op_wr_addr),
        .wr_data(n_wr_data),
        .rd_addr(n_rd_addr),
        .rd_data(n_rd_data)
    );

    block_ram u_m_mem (
        .clk_in (clk_in),
        .wr_en  (m_wr_en),
        .wr_addr(op_wr_addr),
        .wr_data(m_wr_data),
        .rd_addr(m_rd_addr),
        .rd_data(m_rd_data)
    );

    block_ram u_acc_mem (
        .clk_in (clk_in),
        .wr_en  (acc_wr_en),
        .wr_addr(acc_wr_addr),
        .wr_data(acc_wr_data),
        .rd_addr(acc_rd_addr),
        .rd_data(acc_rd_data)
    );

    mul_sequencer u_sequencer (
        .clk_in      (clk_in),
        .rst         (rst),
        .load_done   (load_done),
        .ready       (ready),
        .n_rd_addr   (n_rd_addr),
        .m_rd_addr   (m_rd_addr),
        .acc_rd_addr (acc_rd_addr),
        .step        (issue_ctrl.issue),
        .acc_rd_data (acc_rd_data),
        .result_word (result_word),
        .result_valid(result_valid),
        .result_last (result_last)
    );

    block_multiplier u_multiplier (
        .clk_in    (clk_in),
        .rst       (rst),
        .n_block   (n_rd_data),
        .m_block   (m_rd_data),
        .step_in   (issue_ctrl.relay),
        .step_out  (mac_ctrl.relay),
        .product_lo(product_lo),
        .product_hi(product_hi)
    );

    carry_accumulator u_accumulator (
        .clk_in     (clk_in),
        .rst        (rst),
        .step       (mac_ctrl.consume),
        .product_lo (product_lo),
        .product_hi (product_hi),
        .acc_rd_data(acc_rd_data),
        .acc_wr_en  (acc_wr_en),
        .acc_wr_addr(acc_wr_addr),
        .acc_wr_data(acc_wr_data)
    );

endmodule

/* design/block_multiplier.sv */
module block_multiplier import big_mul_pkg::*; (
    input  logic   clk_in,
    input  logic   rst,
    input  block_t n_block,
    input  block_t m_block,
    mac_ctrl_if.relay step_in,
    mac_ctrl_if.relay step_out,
    output block_t product_lo,
    output block_t product_hi
);

    block_t n_eff;

    // half-width partial products
    block_t pp_ll;
    block_t pp_hl;
    block_t pp_lh;
    block_t pp_hh;

    logic [block_w:0] pp_mid;
    logic [2*block_w-1:0] full;

    logic step_valid_q;
    logic row_start_q;
    logic n_zero_q;
    logic acc_fresh_q;
    addr_t acc_addr_q;

    // the extra step of a row multiplies by a zero block
    assign n_eff = step_in.n_zero ? '0 : n_block;

    always_ff @(posedge clk_in) begin
        pp_ll <= n_eff[word_w-1:0] * m_block[word_w-1:0];
        pp_hl <= n_eff[block_w-1:word_w] * m_block[word_w-1:0];
        pp_lh <= n_eff[word_w-1:0] * m_block[block_w-1:word_w];
        pp_hh <= n_eff[block_w-1:word_w] * m_block[block_w-1:word_w];
    end

    assign pp_mid = {1'b0, pp_hl} + {1'b0, pp_lh};
    assign full = {pp_hh, pp_ll} + ((2 * block_w)'(pp_mid) << word_w);
    assign product_lo = full[block_w-1:0];
    assign product_hi = full[2*block_w-1:block_w];

    always_ff @(posedge clk_in) begin
        if (rst) begin
            step_valid_q <= 1'b0;
        end else begin
            step_valid_q <= step_in.step_valid;
        end
    end

    always_ff @(posedge clk_in) begin
        row_start_q <= step_in.row_start;
        n_zero_q <= step_in.n_zero;
        acc_fresh_q <= step_in.acc_fresh;
        acc_addr_q <= step_in.acc_addr;
    end

    assign step_out.step_valid = step_valid_q;
    assign step_out.row_start = row_start_q;
    assign step_out.n_zero = n_zero_q;
    assign step_out.acc_fresh = acc_fresh_q;
    assign step_out.acc_addr = acc_addr_q;

endmodule

/* design/block_ram.sv */
module block_ram import big_mul_pkg::*; (
    input  logic   clk_in,
    input  logic   wr_en,
    input  addr_t  wr_addr,
    input  block_t wr_data,
    input  addr_t  rd_addr,
    output block_t rd_data
);

    block_t mem [acc_blocks];

    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, one cycle latency
    always_ff @(posedge clk_in) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* design/carry_accumulator.sv */
module carry_accumulator import big_mul_pkg::*; (
    input  logic   clk_in,
    input  logic   rst,
    mac_ctrl_if.consume step,
    input  block_t product_lo,
    input  block_t product_hi,
    input  block_t acc_rd_data,
    output logic   acc_wr_en,
    output addr_t  acc_wr_addr,
    output block_t acc_wr_data
);

    block_t acc_q;
    block_t hi_q;
    logic prod_c_q;
    logic acc_c_q;

    block_t hi_prev;
    logic prod_c_prev;
    logic acc_c_prev;
    block_t acc_in;
    logic [block_w:0] prod_sum;
    logic [block_w:0] acc_sum;

    // read data arrives one cycle before the product, hold it to match
    always_ff @(posedge clk_in) begin
        acc_q <= acc_rd_data;
    end

    // a new row starts its carry chain from zero
    assign hi_prev = step.row_start ? '0 : hi_q;
    assign prod_c_prev = step.row_start ? 1'b0 : prod_c_q;
    assign acc_c_prev = step.row_start ? 1'b0 : acc_c_q;

    // blocks never written in this operation read as zero
    assign acc_in = step.acc_fresh ? '0 : acc_q;

    assign prod_sum = {1'b0, product_lo} + {1'b0, hi_prev} + prod_c_prev;
    assign acc_sum = {1'b0, acc_in} + {1'b0, prod_sum[block_w-1:0]} + acc_c_prev;

    always_ff @(posedge clk_in) begin
        if (rst) begin
            acc_wr_en <= 1'b0;
            hi_q <= '0;
            prod_c_q <= 1'b0;
            acc_c_q <= 1'b0;
        end else begin
            acc_wr_en <= step.step_valid;
            if (step.step_valid) begin
                hi_q <= product_hi;
                prod_c_q <= prod_sum[block_w];
                acc_c_q <= acc_sum[block_w];
            end
        end
    end

    always_ff @(posedge clk_in) begin
        acc_wr_addr <= step.acc_addr;
        acc_wr_data <= acc_sum[block_w-1:0];
    end

endmodule

/* design/mac_ctrl_if.sv */
interface mac_ctrl_if import big_mul_pkg::*; ();

    // one multiply step travelling down the pipeline
    wire step_valid;
    // first step of a row, carries start from zero
    wire row_start;
    wire n_zero;
    // accumulator block not yet written in this operation
    wire acc_fresh;
    wire addr_t acc_addr;

    modport issue (output step_valid, row_start, n_zero, acc_fresh, acc_addr);

    // multiplier reads one instance and drives the next stage
    modport relay (inout step_valid, row_start, n_zero, acc_fresh, acc_addr);

    modport consume (input step_valid, row_start, n_zero, acc_fresh, acc_addr);

endinterface

/* design/mul_sequencer.sv */
module mul_sequencer import big_mul_pkg::*; (
    input  logic   clk_in,
    input  logic   rst,
    input  logic   load_done,
    output logic   ready,
    output addr_t  n_rd_addr,
    output addr_t  m_rd_addr,
    output addr_t  acc_rd_addr,
    mac_ctrl_if.issue step,
    input  block_t acc_rd_data,
    output word_t  result_word,
    output logic   result_valid,
    output logic   result_last
);

    seq_state_t state;

    // compute walk, step_i runs one past the last n block
    addr_t step_i;
    addr_t row_j;
    logic walk_done;
    logic [1:0] drain_cnt;
    logic step_active;

    // output walk, msb set once all words are issued
    logic [out_cnt_w-1:0] out_cnt;
    logic out_issue;

    logic step_valid_q;
    logic row_start_q;
    logic n_zero_q;
    logic acc_fresh_q;
    addr_t acc_addr_q;

    logic out_vld_q;
    logic out_last_q;
    logic out_sel_q;

    assign ready = (state == st_idle) || (state == st_loading);
    assign step_active = (state == st_computing) && !walk_done;
    assign out_issue = (state == st_outputting) && !out_cnt[out_cnt_w-1];

    assign n_rd_addr = step_i;
    assign m_rd_addr = row_j;
    assign acc_rd_addr = (state == st_outputting) ? out_cnt[out_cnt_w-2:1] : step_i + row_j;

    always_ff @(posedge clk_in) begin
        if (rst) begin
            state <= st_idle;
            step_i <= '0;
            row_j <= '0;
            walk_done <= 1'b0;
            drain_cnt <= '0;
            out_cnt <= '0;
        end else begin
            case (state)
                st_idle, st_loading: begin
                    step_i <= '0;
                    row_j <= '0;
                    walk_done <= 1'b0;
                    drain_cnt <= '0;
                    if (load_done) begin
                        state <= st_computing;
                    end else begin
                        state <= st_loading;
                    end
                end
                st_computing: begin
                    if (!walk_done) begin
                        if (step_i == addr_t'(operand_blocks)) begin
                            step_i <= '0;
                            if (row_j == addr_t'(operand_blocks - 1)) begin
                                walk_done <= 1'b1;
                            end else begin
                                row_j <= row_j + 1'b1;
                            end
                        end else begin
                            step_i <= step_i + 1'b1;
                        end
                    end else if (drain_cnt == 2'(drain_cycles - 1)) begin
                        // last accumulator write has landed
                        state <= st_outputting;
                        out_cnt <= '0;
                    end else begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                end
                st_outputting: begin
                    if (!out_cnt[out_cnt_w-1]) begin
                        out_cnt <= out_cnt + 1'b1;
                    end
                    if (result_last) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // step control lines up with the operand read data
    always_ff @(posedge clk_in) begin
        if (rst) begin
            step_valid_q <= 1'b0;
        end else begin
            step_valid_q <= step_active;
        end
    end

    always_ff @(posedge clk_in) begin
        row_start_q <= (step_i == '0);
        n_zero_q <= (step_i == addr_t'(operand_blocks));
        acc_fresh_q <= (row_j == '0) || (step_i == addr_t'(operand_blocks));
        acc_addr_q <= step_i + row_j;
    end

    assign step.step_valid = step_valid_q;
    assign step.row_start = row_start_q;
    assign step.n_zero = n_zero_q;
    assign step.acc_fresh = acc_fresh_q;
    assign step.acc_addr = acc_addr_q;

    // each block is read twice, low word then high word
    always_ff @(posedge clk_in) begin
        if (rst) begin
            out_vld_q <= 1'b0;
            out_last_q <= 1'b0;
            result_valid <= 1'b0;
            result_last <= 1'b0;
        end else begin
            out_vld_q <= out_issue;
            out_last_q <= out_issue && (out_cnt == out_cnt_w'(result_words - 1));
            result_valid <= out_vld_q;
            result_last <= out_last_q;
        end
    end

    always_ff @(posedge clk_in) begin
        out_sel_q <= out_cnt[0];
        result_word <= out_sel_q ? acc_rd_data[block_w-1:word_w] : acc_rd_data[word_w-1:0];
    end

endmodule

/* design/operand_loader.sv */
module operand_loader import big_mul_pkg::*; (
    input  logic   clk_in,
    input  logic   rst,
    input  word_t  operand_n,
    input  word_t  operand_m,
    input  logic   load_valid,
    input  logic   accept,
    output logic   n_wr_en,
    output logic   m_wr_en,
    output addr_t  wr_addr,
    output block_t n_wr_data,
    output block_t m_wr_data,
    output logic   load_done
);

    logic [load_cnt_w-1:0] pair_cnt;
    logic taken;
    word_t held_n;
    word_t held_m;

    // pairs offered while the sequencer is busy are dropped
    assign taken = load_valid && accept;

    always_ff @(posedge clk_in) begin
        if (rst) begin
            pair_cnt <= '0;
        end else if (taken) begin
            if (pair_cnt == load_cnt_w'(load_words - 1)) begin
                pair_cnt <= '0;
            end else begin
                pair_cnt <= pair_cnt + 1'b1;
            end
        end
    end

    // even words wait here for their odd partner
    always_ff @(posedge clk_in) begin
        if (taken && !pair_cnt[0]) begin
            held_n <= operand_n;
            held_m <= operand_m;
        end
    end

    assign n_wr_en = taken && pair_cnt[0];
    assign m_wr_en = taken && pair_cnt[0];
    assign wr_addr = addr_t'(pair_cnt >> 1);
    assign n_wr_data = {operand_n, held_n};
    assign m_wr_data = {operand_m, held_m};
    assign load_done = taken && (pair_cnt == load_cnt_w'(load_words - 1));

endmodule

/* tb/big_mul_tb.sv */
module big_mul_tb import big_mul_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int random_ops = 20;
    localparam int corner_ops = 3;
    localparam int idle_ops = 4;
    localparam int garbage_ops = 3;
    localparam int total_ops = random_ops + corner_ops + idle_ops + garbage_ops;
    localparam int cycle_limit = total_ops * 150;

    logic clk_in;
    logic rst;
    word_t operand_n;
    word_t operand_m;
    logic load_valid;
    logic ready;
    word_t result_word;
    logic result_valid;
    logic result_last;

    integer seed;
    int err_cnt;
    int test_cnt;
    int fail_cnt;
    int cycle_cnt;
    logic [operand_bits-1:0] a_op;
    logic [operand_bits-1:0] b_op;
    logic [operand_bits-1:0] ones_op;

    clk_gen u_clk_gen (
        .clk_in(clk_in),
        .rst   (rst)
    );

    big_mul_top u_dut (
        .clk_in      (clk_in),
        .rst         (rst),
        .operand_n   (operand_n),
        .operand_m   (operand_m),
        .load_valid  (load_valid),
        .ready       (ready),
        .result_word (result_word),
        .result_valid(result_valid),
        .result_last (result_last)
    );

    task automatic check_word(input string tag, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h, actual %h", tag, expected, actual);
            err_cnt++;
        end
    endtask

    task automatic check_flag(input string tag, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %b, actual %b", tag, expected, actual);
            err_cnt++;
        end
    endtask

    // word 0 lands in the lowest bits
    function automatic logic [operand_bits-1:0] rand_operand();
        logic [operand_bits-1:0] op;
        for (int k = 0; k < load_words; k++) begin
            op[k*word_w +: word_w] = $random(seed);
        end
        return op;
    endfunction

    task automatic run_op(input string name, input logic [operand_bits-1:0] n_op,
                          input logic [operand_bits-1:0] m_op, input int idle_max,
                          input bit garbage);
        logic [2*operand_bits-1:0] expected;
        int errs_before;
        int got;
        int gap;
        bit done;
        errs_before = err_cnt;
        expected = {{operand_bits{1'b0}}, n_op} * {{operand_bits{1'b0}}, m_op};

        @(negedge clk_in);
        load_valid = 1'b0;
        while (rst || !ready) begin
            @(negedge clk_in);
        end

        // idle cycles between word pairs carry junk data
        for (int k = 0; k < load_words; k++) begin
            if (idle_max > 0) begin
                gap = {$random(seed)} % (idle_max + 1);
                repeat (gap) begin
                    load_valid = 1'b0;
                    operand_n = $random(seed);
                    operand_m = $random(seed);
                    @(negedge clk_in);
                end
            end
            check_flag({name, " ready during load"}, 1'b1, ready);
            operand_n = n_op[k*word_w +: word_w];
            operand_m = m_op[k*word_w +: word_w];
            load_valid = 1'b1;
            @(negedge clk_in);
        end

        // ready stays low until the frame ends
        got = 0;
        done = 1'b0;
        while (!done) begin
            check_flag({name, " ready while busy"}, 1'b0, ready);
            if (garbage) begin
                load_valid = 1'b1;
                operand_n = $random(seed);
                operand_m = $random(seed);
            end else begin
                load_valid = 1'b0;
            end
            if (result_valid) begin
                check_word($sformatf("%s word %0d", name, got),
                           expected[got*word_w +: word_w], result_word);
                check_flag($sformatf("%s last at word %0d", name, got),
                           got == result_words - 1, result_last);
                got++;
                done = result_last || (got == result_words);
            end else begin
                check_flag({name, " last without valid"}, 1'b0, result_last);
                if (got != 0) begin
                    $display("test %s: result_valid dropped after %0d words", name, got);
                    err_cnt++;
                    done = 1'b1;
                end
            end
            @(negedge clk_in);
        end

        // one cycle after the last word
        load_valid = 1'b0;
        check_flag({name, " ready after last"}, 1'b1, ready);
        check_flag({name, " valid after last"}, 1'b0, result_valid);
        check_flag({name, " last after last"}, 1'b0, result_last);
        if (got != result_words) begin
            $display("test %s: frame held %0d words instead of %0d", name, got, result_words);
            err_cnt++;
        end

        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: %0d errors", name, err_cnt - errs_before);
        end
    endtask

    initial begin
        seed = 32'h8ce84b26;
        err_cnt = 0;
        test_cnt = 0;
        fail_cnt = 0;
        load_valid = 1'b0;
        operand_n = '0;
        operand_m = '0;
        ones_op = '1;

        for (int t = 0; t < random_ops; t++) begin
            a_op = rand_operand();
            b_op = rand_operand();
            run_op($sformatf("random_%0d", t), a_op, b_op, 0, 1'b0);
        end

        // all-ones operands drive every carry to its limit
        a_op = rand_operand();
        run_op("zero_x_ones", '0, ones_op, 0, 1'b0);
        run_op("ones_x_random", ones_op, a_op, 0, 1'b0);
        run_op("ones_x_ones", ones_op, ones_op, 0, 1'b0);

        for (int t = 0; t < idle_ops; t++) begin
            a_op = rand_operand();
            b_op = rand_operand();
            run_op($sformatf("idle_gaps_%0d", t), a_op, b_op, 3, 1'b0);
        end

        for (int t = 0; t < garbage_ops; t++) begin
            a_op = rand_operand();
            b_op = rand_operand();
            run_op($sformatf("busy_garbage_%0d", t), a_op, b_op, 0, 1'b1);
        end

        $display("tests %0d, failed %0d, check errors %0d", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // stops a stuck run
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk_in);
            cycle_cnt++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("** FAIL **");
        $finish;
    end

endmodule

/* tb/clk_gen.sv */
module clk_gen (
    output logic clk_in,
    output logic rst
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int reset_cycles = 4;

    initial begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    // released on a falling edge, after four rising edges
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(negedge clk_in);
        rst = 1'b0;
    end

endmodule
